// ==== hw/ipic_pkg.sv ====
// IPIC shared sizes, types, register map and ICSR field layout
`default_nettype none

package ipic_pkg;

    // ----------------------------
    // Sizes
    // ----------------------------
    localparam int IRQ_LINES = 16;             // External interrupt lines
    localparam int VECT_W    = 5;              // Line index plus void bit
    localparam int IDX_W     = 4;              // Line index width
    localparam int XLEN      = 32;             // Register data width
    localparam int ADDR_W    = 3;              // Register address width

    // ----------------------------
    // Types
    // ----------------------------
    typedef logic [IRQ_LINES-1:0] irq_vec_t;   // One bit per line
    typedef logic [IDX_W-1:0]     irq_idx_t;   // Line number
    typedef logic [VECT_W-1:0]    vect_t;      // Line number or void
    typedef logic [ADDR_W-1:0]    csr_addr_t;
    typedef logic [XLEN-1:0]      csr_data_t;

    // Nothing in service
    localparam vect_t VOID_VECT = vect_t'(IRQ_LINES);

    // ----------------------------
    // Register map
    // ----------------------------
    localparam csr_addr_t ADDR_CISV  = 3'd0;   // Current vector in service
    localparam csr_addr_t ADDR_CICSR = 3'd1;   // Reserved, reads zero
    localparam csr_addr_t ADDR_IPR   = 3'd2;   // Pending bits
    localparam csr_addr_t ADDR_ISVR  = 3'd3;   // In-service bits
    localparam csr_addr_t ADDR_EOI   = 3'd4;   // End of interrupt
    localparam csr_addr_t ADDR_SOI   = 3'd5;   // Start of interrupt
    localparam csr_addr_t ADDR_IDX   = 3'd6;   // Line select for ICSR
    localparam csr_addr_t ADDR_ICSR  = 3'd7;   // Per-line control window

    // ----------------------------
    // ICSR layout
    // ----------------------------
    localparam int ICSR_IP      = 0;           // Pending
    localparam int ICSR_IE      = 1;           // Enable
    localparam int ICSR_IM      = 2;           // Mode, 1 means edge
    localparam int ICSR_INV     = 3;           // Line inversion
    localparam int ICSR_IS      = 4;           // In service
    localparam int ICSR_PRV_LSB = 8;
    localparam int ICSR_PRV_W   = 2;
    localparam int ICSR_LN_LSB  = 12;          // Line number, IDX_W wide

    // Machine privilege, fixed
    localparam logic [ICSR_PRV_W-1:0] PRV_M = 2'd3;

endpackage

`default_nettype wire

// ==== hw/ipic_line_detect.sv ====
// IPIC line front end: two-stage synchronizer with level and edge detection
`default_nettype none

module ipic_line_detect (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire ipic_pkg::irq_vec_t irq_lines_i,   // Raw external lines
    input  wire ipic_pkg::irq_vec_t iinvr_i,       // Per-line inversion
    output ipic_pkg::irq_vec_t     irq_lvl_o,      // Active level after inversion
    output ipic_pkg::irq_vec_t     irq_edge_o      // Rising to active level
);

    ipic_pkg::irq_vec_t lines_meta;    // First sync stage
    ipic_pkg::irq_vec_t lines_sync;    // Second sync stage
    ipic_pkg::irq_vec_t lines_dly;     // Previous synchronized value

    // ----------------------------
    // Synchronizer and delay
    // ----------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lines_meta <= '0;
            lines_sync <= '0;
            lines_dly  <= '0;
        end else begin
            lines_meta <= irq_lines_i;
            lines_sync <= lines_meta;
            lines_dly  <= lines_sync;   // One cycle behind for edges
        end
    end

    // Inversion applies to both level and edge
    assign irq_lvl_o  = lines_sync ^ iinvr_i;

    // Change seen and the new value is the active one
    assign irq_edge_o = (lines_sync ^ lines_dly) & irq_lvl_o;

endmodule

`default_nettype wire

// ==== hw/ipic_prio_enc.sv ====
// IPIC priority encoder: index of the lowest set bit, void when empty
`default_nettype none

module ipic_prio_enc (
    input  wire ipic_pkg::irq_vec_t vec_i,
    output logic                   vd_o,    // Any bit set
    output ipic_pkg::vect_t        idx_o    // Lowest set index or void
);

    // Scan from the top so the lowest index wins
    always_comb begin
        idx_o = ipic_pkg::VOID_VECT;
        for (int i = ipic_pkg::IRQ_LINES - 1; i >= 0; i--) begin
            if (vec_i[i]) begin
                idx_o = ipic_pkg::vect_t'(i);
            end
        end
    end

    assign vd_o = |vec_i;

endmodule

`default_nettype wire

// ==== hw/ipic_line_regs.sv ====
// IPIC per-line registers: pending, enable, mode, inversion and index
`default_nettype none

module ipic_line_regs (
    input  wire logic               clk,
    input  wire logic               rst_n,
    // Register writes
    input  wire ipic_pkg::csr_data_t wdata_i,
    input  wire logic               idx_wr_i,
    input  wire logic               icsr_wr_i,
    input  wire logic               ipr_wr_i,
    // Clear on start of interrupt
    input  wire logic               soi_clr_i,
    input  wire ipic_pkg::irq_idx_t  req_idx_i,
    // From line detection
    input  wire ipic_pkg::irq_vec_t  irq_lvl_i,
    input  wire ipic_pkg::irq_vec_t  irq_edge_i,
    // Register state
    output ipic_pkg::irq_vec_t      ipr_o,
    output ipic_pkg::irq_vec_t      ier_o,
    output ipic_pkg::irq_vec_t      imr_o,
    output ipic_pkg::irq_vec_t      iinvr_o,
    output ipic_pkg::irq_idx_t      idx_o
);

    ipic_pkg::irq_vec_t ier_next;
    ipic_pkg::irq_vec_t imr_next;
    ipic_pkg::irq_vec_t iinvr_next;
    ipic_pkg::irq_vec_t clr_req;     // Software clear requests
    ipic_pkg::irq_vec_t clr_ok;      // Lines where a clear may act
    ipic_pkg::irq_vec_t ipr_next;

    // ----------------------------
    // IDX
    // ----------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_o <= '0;
        end else if (idx_wr_i) begin
            idx_o <= wdata_i[ipic_pkg::IDX_W-1:0];
        end
    end

    // ----------------------------
    // IER, IMR, IINVR
    // ----------------------------
    always_comb begin
        ier_next   = ier_o;
        imr_next   = imr_o;
        iinvr_next = iinvr_o;
        if (icsr_wr_i) begin       // Only the indexed line changes
            ier_next[idx_o]   = wdata_i[ipic_pkg::ICSR_IE];
            imr_next[idx_o]   = wdata_i[ipic_pkg::ICSR_IM];
            iinvr_next[idx_o] = wdata_i[ipic_pkg::ICSR_INV];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ier_o   <= '0;
            imr_o   <= '0;
            iinvr_o <= '0;
        end else begin
            ier_o   <= ier_next;
            imr_o   <= imr_next;
            iinvr_o <= iinvr_next;
        end
    end

    // ----------------------------
    // IPR
    // ----------------------------
    always_comb begin
        clr_req = '0;
        if (ipr_wr_i) begin
            clr_req = wdata_i[ipic_pkg::IRQ_LINES-1:0];   // Write 1 to clear
        end
        if (icsr_wr_i) begin
            clr_req[idx_o] = wdata_i[ipic_pkg::ICSR_IP];
        end
        if (soi_clr_i) begin
            clr_req[req_idx_i] = 1'b1;                    // Started line
        end
    end

    // A held active level in level mode keeps its pending bit
    assign clr_ok = ~irq_lvl_i | imr_next;

    always_comb begin
        for (int i = 0; i < ipic_pkg::IRQ_LINES; i++) begin
            if (clr_req[i] && clr_ok[i]) begin
                ipr_next[i] = 1'b0;
            end else if (!imr_o[i]) begin
                ipr_next[i] = irq_lvl_i[i];               // Level follows line
            end else begin
                ipr_next[i] = ipr_o[i] | irq_edge_i[i];   // Edge is sticky
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ipr_o <= '0;
        end else begin
            ipr_o <= ipr_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ipic_service.sv ====
// IPIC service tracking: CISV and ISVR, SOI and EOI, priority request output
`default_nettype none

module ipic_service (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              soi_wr_i,
    input  wire logic              eoi_wr_i,
    input  wire ipic_pkg::irq_vec_t ipr_i,
    input  wire ipic_pkg::irq_vec_t ier_i,
    output logic                   soi_clr_o,     // Clear pending of started line
    output ipic_pkg::irq_idx_t     req_idx_o,
    output ipic_pkg::vect_t        cisv_o,
    output ipic_pkg::irq_vec_t     isvr_o,
    output logic                   irq_m_req_o
);

    logic               req_vd;
    ipic_pkg::vect_t    req_vect;     // Best enabled pending line
    logic               serv_vd;
    ipic_pkg::irq_idx_t serv_idx;
    logic               start;        // SOI accepted
    logic               eoi;          // EOI with something in service
    ipic_pkg::irq_vec_t isvr_eoi;     // ISVR with current line removed
    logic               eoi_vd;
    ipic_pkg::vect_t    eoi_vect;     // Next line left in service

    // ----------------------------
    // Priority
    // ----------------------------
    ipic_prio_enc u_req_enc (
        .vec_i (ipr_i & ier_i),
        .vd_o  (req_vd),
        .idx_o (req_vect)
    );

    assign serv_vd   = ~cisv_o[ipic_pkg::VECT_W-1];   // Void bit clear
    assign serv_idx  = cisv_o[ipic_pkg::IDX_W-1:0];
    assign req_idx_o = req_vect[ipic_pkg::IDX_W-1:0];

    // Request when idle, or when the request outranks the one in service
    assign irq_m_req_o = req_vd & (~serv_vd | (req_vect < cisv_o));

    assign start     = soi_wr_i & irq_m_req_o;
    assign soi_clr_o = soi_wr_i & req_vd;
    assign eoi       = eoi_wr_i & serv_vd;

    // ----------------------------
    // Next in service after EOI
    // ----------------------------
    always_comb begin
        isvr_eoi = isvr_o;
        isvr_eoi[serv_idx] = 1'b0;
    end

    ipic_prio_enc u_eoi_enc (
        .vec_i (isvr_eoi),
        .vd_o  (eoi_vd),
        .idx_o (eoi_vect)
    );

    // ----------------------------
    // CISV and ISVR
    // ----------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cisv_o <= ipic_pkg::VOID_VECT;
            isvr_o <= '0;
        end else if (start) begin
            cisv_o <= req_vect;               // Nest on the new line
            isvr_o[req_idx_o] <= 1'b1;
        end else if (eoi) begin
            cisv_o <= eoi_vd ? eoi_vect : ipic_pkg::VOID_VECT;
            isvr_o <= isvr_eoi;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ipic_csr_access.sv ====
// IPIC register port: write strobe decode and read data multiplexer
`default_nettype none

module ipic_csr_access (
    input  wire logic               r_req_i,
    input  wire logic               w_req_i,
    input  wire ipic_pkg::csr_addr_t addr_i,
    input  wire ipic_pkg::irq_vec_t  ipr_i,
    input  wire ipic_pkg::irq_vec_t  ier_i,
    input  wire ipic_pkg::irq_vec_t  imr_i,
    input  wire ipic_pkg::irq_vec_t  iinvr_i,
    input  wire ipic_pkg::irq_vec_t  isvr_i,
    input  wire ipic_pkg::irq_idx_t  idx_i,
    input  wire ipic_pkg::vect_t     cisv_i,
    output ipic_pkg::csr_data_t     rdata_o,
    output logic                    idx_wr_o,
    output logic                    icsr_wr_o,
    output logic                    ipr_wr_o,
    output logic                    soi_wr_o,
    output logic                    eoi_wr_o
);

    // ----------------------------
    // Write decode
    // ----------------------------
    always_comb begin
        idx_wr_o  = 1'b0;
        icsr_wr_o = 1'b0;
        ipr_wr_o  = 1'b0;
        soi_wr_o  = 1'b0;
        eoi_wr_o  = 1'b0;
        if (w_req_i) begin
            case (addr_i)
                ipic_pkg::ADDR_IPR:  ipr_wr_o  = 1'b1;
                ipic_pkg::ADDR_EOI:  eoi_wr_o  = 1'b1;
                ipic_pkg::ADDR_SOI:  soi_wr_o  = 1'b1;
                ipic_pkg::ADDR_IDX:  idx_wr_o  = 1'b1;
                ipic_pkg::ADDR_ICSR: icsr_wr_o = 1'b1;
                default: ;                      // CISV, ISVR, CICSR read only
            endcase
        end
    end

    // ----------------------------
    // Read mux
    // ----------------------------
    always_comb begin
        rdata_o = '0;                            // Zero outside a read
        if (r_req_i) begin
            case (addr_i)
                ipic_pkg::ADDR_CISV: rdata_o = ipic_pkg::csr_data_t'(cisv_i);
                ipic_pkg::ADDR_IPR:  rdata_o = ipic_pkg::csr_data_t'(ipr_i);
                ipic_pkg::ADDR_ISVR: rdata_o = ipic_pkg::csr_data_t'(isvr_i);
                ipic_pkg::ADDR_IDX:  rdata_o = ipic_pkg::csr_data_t'(idx_i);
                ipic_pkg::ADDR_ICSR: begin       // Indexed line view
                    rdata_o[ipic_pkg::ICSR_IP]  = ipr_i[idx_i];
                    rdata_o[ipic_pkg::ICSR_IE]  = ier_i[idx_i];
                    rdata_o[ipic_pkg::ICSR_IM]  = imr_i[idx_i];
                    rdata_o[ipic_pkg::ICSR_INV] = iinvr_i[idx_i];
                    rdata_o[ipic_pkg::ICSR_IS]  = isvr_i[idx_i];
                    rdata_o[ipic_pkg::ICSR_PRV_LSB +: ipic_pkg::ICSR_PRV_W] = ipic_pkg::PRV_M;
                    rdata_o[ipic_pkg::ICSR_LN_LSB +: ipic_pkg::IDX_W]       = idx_i;
                end
                ipic_pkg::ADDR_CICSR,
                ipic_pkg::ADDR_EOI,
                ipic_pkg::ADDR_SOI:  rdata_o = '0;
                default:             rdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/ipic_top.sv ====
// IPIC top level: sixteen-line interrupt controller with CPU register port
`default_nettype none

module ipic_top (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire ipic_pkg::irq_vec_t  irq_lines_i,   // External interrupt lines
    input  wire logic               r_req_i,       // Read strobe
    input  wire logic               w_req_i,       // Write strobe
    input  wire ipic_pkg::csr_addr_t addr_i,
    input  wire ipic_pkg::csr_data_t wdata_i,
    output ipic_pkg::csr_data_t     rdata_o,       // Valid with r_req_i
    output logic                    irq_m_req_o    // To the CPU
);

    // ----------------------------
    // Internal wiring
    // ----------------------------
    ipic_pkg::irq_vec_t irq_lvl;
    ipic_pkg::irq_vec_t irq_edge;
    ipic_pkg::irq_vec_t ipr;
    ipic_pkg::irq_vec_t ier;
    ipic_pkg::irq_vec_t imr;
    ipic_pkg::irq_vec_t iinvr;
    ipic_pkg::irq_vec_t isvr;
    ipic_pkg::irq_idx_t idx;
    ipic_pkg::irq_idx_t req_idx;
    ipic_pkg::vect_t    cisv;
    logic               idx_wr;
    logic               icsr_wr;
    logic               ipr_wr;
    logic               soi_wr;
    logic               eoi_wr;
    logic               soi_clr;

    ipic_line_detect u_line_detect (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines_i),
        .iinvr_i     (iinvr),
        .irq_lvl_o   (irq_lvl),
        .irq_edge_o  (irq_edge)
    );

    ipic_line_regs u_line_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .wdata_i    (wdata_i),
        .idx_wr_i   (idx_wr),
        .icsr_wr_i  (icsr_wr),
        .ipr_wr_i   (ipr_wr),
        .soi_clr_i  (soi_clr),
        .req_idx_i  (req_idx),
        .irq_lvl_i  (irq_lvl),
        .irq_edge_i (irq_edge),
        .ipr_o      (ipr),
        .ier_o      (ier),
        .imr_o      (imr),
        .iinvr_o    (iinvr),
        .idx_o      (idx)
    );

    ipic_service u_service (
        .clk         (clk),
        .rst_n       (rst_n),
        .soi_wr_i    (soi_wr),
        .eoi_wr_i    (eoi_wr),
        .ipr_i       (ipr),
        .ier_i       (ier),
        .soi_clr_o   (soi_clr),
        .req_idx_o   (req_idx),
        .cisv_o      (cisv),
        .isvr_o      (isvr),
        .irq_m_req_o (irq_m_req_o)
    );

    ipic_csr_access u_csr_access (
        .r_req_i   (r_req_i),
        .w_req_i   (w_req_i),
        .addr_i    (addr_i),
        .ipr_i     (ipr),
        .ier_i     (ier),
        .imr_i     (imr),
        .iinvr_i   (iinvr),
        .isvr_i    (isvr),
        .idx_i     (idx),
        .cisv_i    (cisv),
        .rdata_o   (rdata_o),
        .idx_wr_o  (idx_wr),
        .icsr_wr_o (icsr_wr),
        .ipr_wr_o  (ipr_wr),
        .soi_wr_o  (soi_wr),
        .eoi_wr_o  (eoi_wr)
    );

endmodule

`default_nettype wire

// ==== test/ipic_asserts.sv ====
// IPIC bound checks on the register port and the request output
`default_nettype none

module ipic_asserts (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               r_req_i,
    input  wire ipic_pkg::csr_data_t rdata_i,
    input  wire ipic_pkg::irq_vec_t  ier_i,
    input  wire logic               irq_req_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fire_cnt = 0;         // Failures seen so far

    // Read data is quiet outside a read
    a_rdata_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !r_req_i |-> rdata_i == '0)
        else begin
            $error("read data not zero while no read is active");
            fire_cnt++;
        end

    a_req_disabled: assert property (@(posedge clk) disable iff (!rst_n)
        ier_i == '0 |-> !irq_req_i)     // No enabled line, no request
        else begin
            $error("interrupt request raised with every line disabled");
            fire_cnt++;
        end

endmodule

bind ipic_top ipic_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .r_req_i   (r_req_i),
    .rdata_i   (rdata_o),
    .ier_i     (ier),
    .irq_req_i (irq_m_req_o)
);

`default_nettype wire

// ==== test/ipic_tb.sv ====
// IPIC testbench: register-port stimulus checked against a settled reference model
`default_nettype none

module ipic_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SETTLE     = 6;                 // Idle cycles before any read
    localparam int TEST_LIMIT = 800;               // Longest test stays well below
    localparam int MAX_CYCLES = 5 * TEST_LIMIT;    // Five tests
    localparam ipic_pkg::vect_t NONE = 5'd16;      // Nothing in service
    localparam ipic_pkg::csr_data_t CFG_IP  = 32'h1;
    localparam ipic_pkg::csr_data_t CFG_IE  = 32'h2;
    localparam ipic_pkg::csr_data_t CFG_IM  = 32'h4;    // Edge mode
    localparam ipic_pkg::csr_data_t CFG_INV = 32'h8;

    logic                clk;
    logic                rst_n;
    ipic_pkg::irq_vec_t  irq_lines;
    logic                r_req;
    logic                w_req;
    ipic_pkg::csr_addr_t addr;
    ipic_pkg::csr_data_t wdata;
    ipic_pkg::csr_data_t rdata;
    logic                irq_req;

    // Reference state, always the settled view
    ipic_pkg::irq_vec_t m_lines;
    ipic_pkg::irq_vec_t m_ipr;
    ipic_pkg::irq_vec_t m_ier;
    ipic_pkg::irq_vec_t m_imr;
    ipic_pkg::irq_vec_t m_iinvr;
    ipic_pkg::irq_vec_t m_isvr;
    ipic_pkg::vect_t    m_cisv;
    ipic_pkg::irq_idx_t m_idx;

    logic [31:0] lfsr;
    int          cycle_cnt = 0;
    int          test_cnt;
    int          check_cnt;
    int          err_cnt;
    int          test_base;        // Errors before the current test

    ipic_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines),
        .r_req_i     (r_req),
        .w_req_i     (w_req),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .rdata_o     (rdata),
        .irq_m_req_o (irq_req)
    );

    always #20 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ----------------------------
    // Random numbers and helpers
    // ----------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);   // Galois step
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic ipic_pkg::irq_vec_t one_hot(input ipic_pkg::irq_idx_t ln);
        ipic_pkg::irq_vec_t r;
        r = '0;
        r[ln] = 1'b1;
        return r;
    endfunction

    function automatic ipic_pkg::vect_t lowest(input ipic_pkg::irq_vec_t v);
        ipic_pkg::vect_t r;
        r = NONE;
        for (int i = 0; i < 16; i++) begin
            if (v[i] && r == NONE) begin
                r = ipic_pkg::vect_t'(i);      // First hit wins
            end
        end
        return r;
    endfunction

    // ----------------------------
    // Reference model
    // ----------------------------
    function automatic logic exp_req();
        ipic_pkg::vect_t best;
        best = lowest(m_ipr & m_ier);
        return (best != NONE) && (m_cisv == NONE || best < m_cisv);
    endfunction

    // One write, or a new line value when is_wr is low
    function automatic void ref_model(input logic is_wr, input ipic_pkg::csr_addr_t a,
                                      input ipic_pkg::csr_data_t d);
        ipic_pkg::irq_vec_t clr;
        ipic_pkg::irq_vec_t nl;
        ipic_pkg::vect_t    best;
        clr = '0;
        nl  = d[15:0];
        if (!is_wr) begin
            m_ipr   = m_ipr | (m_imr & (m_lines ^ nl) & (nl ^ m_iinvr));   // Edge to active
            m_lines = nl;
        end else begin
            case (a)
                ipic_pkg::ADDR_IDX:  m_idx = d[3:0];
                ipic_pkg::ADDR_IPR:  clr = nl;
                ipic_pkg::ADDR_ICSR: begin
                    m_ier[m_idx]   = d[1];
                    m_imr[m_idx]   = d[2];
                    m_iinvr[m_idx] = d[3];
                    clr[m_idx]     = d[0];
                end
                ipic_pkg::ADDR_SOI: begin
                    best = lowest(m_ipr & m_ier);
                    if (exp_req()) begin
                        m_isvr[best[3:0]] = 1'b1;
                        m_cisv = best;
                    end
                    if (best != NONE) begin
                        clr[best[3:0]] = 1'b1;   // Cleared even without a start
                    end
                end
                ipic_pkg::ADDR_EOI: begin
                    if (m_cisv != NONE) begin
                        m_isvr[m_cisv[3:0]] = 1'b0;
                        m_cisv = lowest(m_isvr);
                    end
                end
                default: ;
            endcase
        end
        // Edge bits keep state unless cleared, level bits track the line
        m_ipr = m_ipr & ~(clr & m_imr);
        m_ipr = (m_ipr & m_imr) | ((m_lines ^ m_iinvr) & ~m_imr);
    endfunction

    function automatic ipic_pkg::csr_data_t exp_read(input ipic_pkg::csr_addr_t a);
        ipic_pkg::csr_data_t r;
        r = '0;
        case (a)
            ipic_pkg::ADDR_CISV: r[4:0]  = m_cisv;
            ipic_pkg::ADDR_IPR:  r[15:0] = m_ipr;
            ipic_pkg::ADDR_ISVR: r[15:0] = m_isvr;
            ipic_pkg::ADDR_IDX:  r[3:0]  = m_idx;
            ipic_pkg::ADDR_ICSR: begin
                r[0]     = m_ipr[m_idx];
                r[1]     = m_ier[m_idx];
                r[2]     = m_imr[m_idx];
                r[3]     = m_iinvr[m_idx];
                r[4]     = m_isvr[m_idx];
                r[9:8]   = 2'd3;            // Machine mode
                r[15:12] = m_idx;
            end
            default: ;
        endcase
        return r;
    endfunction

    // ----------------------------
    // Compare tasks
    // ----------------------------
    task automatic check_data(input string what, input ipic_pkg::csr_data_t got,
                              input ipic_pkg::csr_data_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s read %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_req(input string what, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s irq request %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // ----------------------------
    // Bus and line tasks
    // ----------------------------
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic reg_write(input ipic_pkg::csr_addr_t a, input ipic_pkg::csr_data_t d);
        w_req = 1'b1;
        addr  = a;
        wdata = d;
        @(posedge clk);
        #2;
        w_req = 1'b0;
        wdata = '0;
        ref_model(1'b1, a, d);
        idle(SETTLE);
    endtask

    task automatic reg_read(input ipic_pkg::csr_addr_t a, output ipic_pkg::csr_data_t d);
        r_req = 1'b1;
        addr  = a;
        @(negedge clk);                    // Mid-cycle, data is steady
        d = rdata;
        @(posedge clk);
        #2;
        r_req = 1'b0;
    endtask

    task automatic read_check(input ipic_pkg::csr_addr_t a, input string what);
        ipic_pkg::csr_data_t got;
        reg_read(a, got);
        check_data(what, got, exp_read(a));
    endtask

    task automatic req_check(input string what);
        @(negedge clk);
        check_req(what, irq_req, exp_req());
        @(posedge clk);
        #2;
    endtask

    task automatic set_line(input ipic_pkg::irq_idx_t ln, input ipic_pkg::csr_data_t cfg);
        reg_write(ipic_pkg::ADDR_IDX, ipic_pkg::csr_data_t'(ln));
        reg_write(ipic_pkg::ADDR_ICSR, cfg);
    endtask

    task automatic drive_lines(input ipic_pkg::irq_vec_t v);
        irq_lines = v;
        ref_model(1'b0, '0, ipic_pkg::csr_data_t'(v));
        idle(SETTLE);
    endtask

    // Lines high for one cycle, then low
    task automatic pulse_lines(input ipic_pkg::irq_vec_t v);
        irq_lines = v;
        ref_model(1'b0, '0, ipic_pkg::csr_data_t'(v));
        @(posedge clk);
        #2;
        irq_lines = '0;
        ref_model(1'b0, '0, '0);
        idle(SETTLE);
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - test_base);
        test_base = err_cnt;
    endtask

    // ----------------------------
    // Test sequence
    // ----------------------------
    initial begin
        ipic_pkg::irq_idx_t  ln;
        ipic_pkg::irq_idx_t  hi_ln;        // Highest priority of the three
        ipic_pkg::irq_idx_t  mid_ln;
        ipic_pkg::irq_idx_t  lo_ln;
        ipic_pkg::csr_data_t cfg;
        clk       = 1'b0;
        rst_n     = 1'b0;
        irq_lines = '0;
        r_req     = 1'b0;
        w_req     = 1'b0;
        addr      = '0;
        wdata     = '0;
        lfsr      = 32'hc6e6;
        m_lines   = '0;
        m_ipr     = '0;
        m_ier     = '0;
        m_imr     = '0;
        m_iinvr   = '0;
        m_isvr    = '0;
        m_cisv    = NONE;
        m_idx     = '0;
        test_cnt  = 0;
        check_cnt = 0;
        err_cnt   = 0;
        test_base = 0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        idle(2);

        // Reset values, then random per-line configuration
        read_check(ipic_pkg::ADDR_CISV, "reset CISV");
        read_check(ipic_pkg::ADDR_IPR, "reset IPR");
        read_check(ipic_pkg::ADDR_ISVR, "reset ISVR");
        read_check(ipic_pkg::ADDR_IDX, "reset IDX");
        req_check("reset");
        repeat (6) begin
            ln  = ipic_pkg::irq_idx_t'(rand_bits(4));
            cfg = rand_bits(3) << 1;                // IE, IM, INV
            set_line(ln, cfg);
            read_check(ipic_pkg::ADDR_ICSR, "ICSR readback");
            req_check("after config");
        end
        for (int i = 0; i < 16; i++) begin
            set_line(ipic_pkg::irq_idx_t'(i), CFG_IP);
        end
        end_test("reset and config");

        // Level mode
        ln = ipic_pkg::irq_idx_t'(rand_bits(4));
        set_line(ln, CFG_IE);
        drive_lines(one_hot(ln));
        read_check(ipic_pkg::ADDR_IPR, "level high IPR");
        req_check("level high");
        reg_write(ipic_pkg::ADDR_IPR, ipic_pkg::csr_data_t'(one_hot(ln)));
        read_check(ipic_pkg::ADDR_IPR, "level clear while high");
        drive_lines('0);
        read_check(ipic_pkg::ADDR_IPR, "level low IPR");
        req_check("level low");
        set_line(ln, '0);
        end_test("level mode");

        // Edge mode
        ln = ipic_pkg::irq_idx_t'(rand_bits(4));
        set_line(ln, CFG_IE | CFG_IM);
        pulse_lines(one_hot(ln));
        read_check(ipic_pkg::ADDR_IPR, "edge latched IPR");
        req_check("edge latched");
        reg_write(ipic_pkg::ADDR_IPR, ipic_pkg::csr_data_t'(one_hot(ln)));
        read_check(ipic_pkg::ADDR_IPR, "edge cleared IPR");
        req_check("edge cleared");
        set_line(ln, CFG_IP);
        end_test("edge mode");

        // Inverted line, active low
        ln = ipic_pkg::irq_idx_t'(rand_bits(4));
        set_line(ln, CFG_IE | CFG_INV);
        read_check(ipic_pkg::ADDR_IPR, "inverted low IPR");
        req_check("inverted low");
        drive_lines(one_hot(ln));
        read_check(ipic_pkg::ADDR_IPR, "inverted high IPR");
        req_check("inverted high");
        drive_lines('0);
        set_line(ln, '0);
        read_check(ipic_pkg::ADDR_IPR, "inversion removed IPR");
        end_test("inversion");

        // Priority, nesting and EOI order
        hi_ln  = ipic_pkg::irq_idx_t'(rand_bits(2));
        mid_ln = ipic_pkg::irq_idx_t'(4 + rand_bits(2));
        lo_ln  = ipic_pkg::irq_idx_t'(8 + rand_bits(3));
        set_line(hi_ln, CFG_IE | CFG_IM);
        set_line(mid_ln, CFG_IE | CFG_IM);
        set_line(lo_ln, CFG_IE | CFG_IM);
        pulse_lines(one_hot(mid_ln) | one_hot(lo_ln));
        read_check(ipic_pkg::ADDR_IPR, "two pending IPR");
        req_check("two pending");
        reg_write(ipic_pkg::ADDR_SOI, '0);
        read_check(ipic_pkg::ADDR_CISV, "first SOI CISV");
        read_check(ipic_pkg::ADDR_ISVR, "first SOI ISVR");
        read_check(ipic_pkg::ADDR_IPR, "first SOI IPR");
        req_check("lower line waits");
        pulse_lines(one_hot(hi_ln));
        req_check("higher arrival");
        reg_write(ipic_pkg::ADDR_SOI, '0);
        read_check(ipic_pkg::ADDR_CISV, "nested CISV");
        read_check(ipic_pkg::ADDR_ISVR, "nested ISVR");
        reg_write(ipic_pkg::ADDR_EOI, '0);
        read_check(ipic_pkg::ADDR_CISV, "first EOI CISV");
        read_check(ipic_pkg::ADDR_ISVR, "first EOI ISVR");
        reg_write(ipic_pkg::ADDR_EOI, '0);
        read_check(ipic_pkg::ADDR_CISV, "second EOI CISV");
        req_check("remaining pending");
        reg_write(ipic_pkg::ADDR_SOI, '0);
        read_check(ipic_pkg::ADDR_CISV, "last SOI CISV");
        reg_write(ipic_pkg::ADDR_EOI, '0);
        read_check(ipic_pkg::ADDR_CISV, "idle CISV");
        read_check(ipic_pkg::ADDR_ISVR, "idle ISVR");
        set_line(hi_ln, CFG_IP);
        set_line(mid_ln, CFG_IP);
        set_line(lo_ln, CFG_IP);
        end_test("priority and service");

        err_cnt += dut.u_asserts.fire_cnt;     // Bound assertion failures
        $display("Done: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_cnt, check_cnt, err_cnt, dut.u_asserts.fire_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/ipic_pkg.sv
hw/ipic_line_detect.sv
hw/ipic_prio_enc.sv
hw/ipic_line_regs.sv
hw/ipic_service.sv
hw/ipic_csr_access.sv
hw/ipic_top.sv
test/ipic_asserts.sv
test/ipic_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the IPIC testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module ipic_tb -o ipic_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ipic_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "Failures found in $LOG"
    exit 1
fi

echo "No failures found in $LOG"
exit 0
